// File: logic/ifu_pkg.sv
// Shared widths, reset PC and step sizes of the instruction fetch unit
// Instruction length enum and the packed port structs
`default_nettype none

package ifu_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Widths and constants
  ////////////////////////////////////////////////////////////////////////////

  localparam int unsigned PC_SIZE    = 32;
  localparam int unsigned INSTR_SIZE = 32;

  typedef logic [PC_SIZE-1:0]    pc_t;
  typedef logic [INSTR_SIZE-1:0] instr_t;

  // PC register value out of reset
  localparam pc_t RESET_PC   = 32'h8000_0000;
  // Sequential steps for compressed and full-size instructions
  localparam pc_t PC_INCR_16 = 32'd2;
  localparam pc_t PC_INCR_32 = 32'd4;

  ////////////////////////////////////////////////////////////////////////////
  // Types
  ////////////////////////////////////////////////////////////////////////////

  // Length from instr[1:0], only 2'b11 is a 32-bit instruction
  typedef enum logic {
    ILEN_16 = 1'b0,
    ILEN_32 = 1'b1
  } ilen_e;

  // Flush target given as two addends, summed inside the PC generator
  typedef struct packed {
    pc_t add_op1;
    pc_t add_op2;
  } flush_t;

  // Fetch request toward memory
  typedef struct packed {
    pc_t  pc;
    logic seq;
    pc_t  last_pc;
  } fetch_req_t;

  // Fetch response from memory
  typedef struct packed {
    instr_t instr;
    logic   err;
  } fetch_rsp_t;

  // IR stage content toward the execute stage
  typedef struct packed {
    instr_t ir;
    pc_t    pc;
    logic   buserr;
  } ir_out_t;

  // Control flags from the PC generator
  typedef struct packed {
    logic flush_real;
    logic reset_req;
  } ctl_t;

endpackage

`default_nettype wire

// File: logic/ifu_pc_gen.sv
// PC generator: PC register and next-PC selection
// Reset flag, reset request and delayed flush tracking
`default_nettype none

module ifu_pc_gen (
  input  logic            clk,
  input  logic            arst_n,
  input  ifu_pkg::pc_t    pc_rtvec,
  input  logic            flush_req,
  input  ifu_pkg::flush_t flush,
  input  logic            req_fire,
  input  ifu_pkg::ilen_e  ilen,
  output ifu_pkg::ctl_t   ctl,
  output ifu_pkg::pc_t    pc_r,
  output ifu_pkg::pc_t    pc_nxt,
  output logic            pc_load
);
  import ifu_pkg::*;

  logic reset_flag_r;
  logic reset_req_r;
  logic reset_pend;
  logic dly_flush_r;
  pc_t  pc_incr;
  pc_t  add_op1;
  pc_t  add_op2;
  pc_t  pc_sum;

  ////////////////////////////////////////////////////////////////////////////
  // Reset request
  ////////////////////////////////////////////////////////////////////////////

  // High while in reset, drops on the first clock edge after release
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      reset_flag_r <= 1'b1;
    end else begin
      reset_flag_r <= 1'b0;
    end
  end

  // Keeps the reset-vector fetch pending until a request is accepted
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      reset_req_r <= 1'b0;
    end else if (reset_flag_r && !req_fire) begin
      reset_req_r <= 1'b1;
    end else if (req_fire) begin
      reset_req_r <= 1'b0;
    end
  end

  // Flag and request seen as one pending condition downstream
  assign reset_pend = reset_flag_r | reset_req_r;

  ////////////////////////////////////////////////////////////////////////////
  // Delayed flush
  ////////////////////////////////////////////////////////////////////////////

  // Flush is never refused; without a request transfer it is remembered
  // here and replayed from pc_r, which already holds the flush target
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      dly_flush_r <= 1'b0;
    end else if (flush_req && !req_fire) begin
      dly_flush_r <= 1'b1;
    end else if (req_fire) begin
      dly_flush_r <= 1'b0;
    end
  end

  assign ctl.flush_real = flush_req | dly_flush_r;
  assign ctl.reset_req  = reset_pend;

  ////////////////////////////////////////////////////////////////////////////
  // Next PC
  ////////////////////////////////////////////////////////////////////////////

  assign pc_incr = (ilen == ILEN_32) ? PC_INCR_32 : PC_INCR_16;

  // Priority: live flush, delayed flush, reset vector, sequential
  always_comb begin
    if (flush_req) begin
      add_op1 = flush.add_op1;
      add_op2 = flush.add_op2;
    end else if (dly_flush_r) begin
      add_op1 = pc_r;
      add_op2 = '0;
    end else if (reset_pend) begin
      add_op1 = pc_rtvec;
      add_op2 = '0;
    end else begin
      add_op1 = pc_r;
      add_op2 = pc_incr;
    end
  end

  assign pc_sum = add_op1 + add_op2;
  // Halfword aligned
  assign pc_nxt = {pc_sum[PC_SIZE-1:1], 1'b0};

  // PC moves on every request transfer and on every flush
  assign pc_load = req_fire | flush_req;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      pc_r <= RESET_PC;
    end else if (pc_load) begin
      pc_r <= pc_nxt;
    end
  end

endmodule

`default_nettype wire

// File: logic/ifu_req_ctrl.sv
// Request controller: fetch request valid, response ready
// Outstanding-request flag and halt acknowledge
`default_nettype none

module ifu_req_ctrl (
  input  logic          clk,
  input  logic          arst_n,
  input  ifu_pkg::ctl_t ctl,
  input  logic          halt_req,
  input  logic          req_ready,
  input  logic          rsp_valid,
  input  logic          ir_ready,
  output logic          req_valid,
  output logic          rsp_ready,
  output logic          req_fire,
  output logic          rsp_fire,
  output logic          halt_ack
);

  logic out_flag_r;
  logic new_req;
  logic new_req_condi;
  logic no_outs;

  assign req_fire = req_valid & req_ready;
  assign rsp_fire = rsp_valid & rsp_ready;

  ////////////////////////////////////////////////////////////////////////////
  // Outstanding request
  ////////////////////////////////////////////////////////////////////////////

  // A new transfer in the same cycle as the response keeps it set
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      out_flag_r <= 1'b0;
    end else if (req_fire) begin
      out_flag_r <= 1'b1;
    end else if (rsp_fire) begin
      out_flag_r <= 1'b0;
    end
  end

  // Room for a request: none outstanding, or it is returning now
  assign new_req_condi = !out_flag_r || rsp_fire;

  ////////////////////////////////////////////////////////////////////////////
  // Request and response handshakes
  ////////////////////////////////////////////////////////////////////////////

  // Sequential fetch stops for halt and while reset is pending
  assign new_req = !halt_req && !ctl.reset_req;

  assign req_valid = (new_req || ctl.reset_req || ctl.flush_real) && new_req_condi;

  // Flush drains the response unconditionally, it gets dropped.
  // Otherwise wait for IR room and for the request side to be ready,
  // so the response and the follow-up request move together
  assign rsp_ready = ctl.flush_real || (ir_ready && req_ready);

  ////////////////////////////////////////////////////////////////////////////
  // Halt acknowledge
  ////////////////////////////////////////////////////////////////////////////

  // A valid response counts as nothing outstanding, since the IR may
  // never take it while the core is waiting
  assign no_outs = !out_flag_r || rsp_valid;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      halt_ack <= 1'b0;
    end else if (halt_req && !halt_ack && no_outs) begin
      halt_ack <= 1'b1;
    end else if (halt_ack && !halt_req) begin
      halt_ack <= 1'b0;
    end
  end

endmodule

`default_nettype wire

// File: logic/ifu_ir_stage.sv
// IR stage: length mini-decode, instruction, PC and bus-error registers
// IR valid, PC valid and new-PC-pending flags toward the execute stage
`default_nettype none

module ifu_ir_stage (
  input  logic                clk,
  input  logic                arst_n,
  input  ifu_pkg::fetch_rsp_t rsp,
  input  logic                rsp_fire,
  input  ifu_pkg::ctl_t       ctl,
  input  logic                flush_req,
  input  logic                pc_load,
  input  ifu_pkg::pc_t        pc_r,
  input  logic                o_ready,
  output ifu_pkg::ilen_e      ilen,
  output logic                ir_ready,
  output logic                o_valid,
  output logic                o_pc_vld,
  output ifu_pkg::ir_out_t    o
);
  import ifu_pkg::*;

  logic   ir_valid_r;
  logic   ir_pc_vld_r;
  logic   pc_newpend_r;
  logic   o_fire;
  logic   ir_valid_set;
  logic   ir_valid_clr;
  logic   ir_pc_vld_set;
  instr_t ir_r;
  pc_t    ir_pc_r;
  logic   ir_err_r;

  // Both low bits set means a full 32-bit instruction
  assign ilen = (rsp.instr[1:0] == 2'b11) ? ILEN_32 : ILEN_16;

  assign o_fire = o_valid & o_ready;

  ////////////////////////////////////////////////////////////////////////////
  // Valid flags
  ////////////////////////////////////////////////////////////////////////////

  // Load on response unless a flush (live or delayed) kills it
  assign ir_valid_set  = rsp_fire && !ctl.flush_real;
  // PC copy waits for a fresh PC and room in the IR
  assign ir_pc_vld_set = pc_newpend_r && ir_ready && !ctl.flush_real;
  assign ir_valid_clr  = o_fire || (flush_req && ir_valid_r);

  // Empty, or emptying this cycle
  assign ir_ready = !ir_valid_r || ir_valid_clr;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      ir_valid_r  <= 1'b0;
      ir_pc_vld_r <= 1'b0;
    end else begin
      if (ir_valid_set) begin
        ir_valid_r <= 1'b1;
      end else if (ir_valid_clr) begin
        ir_valid_r <= 1'b0;
      end
      // Same clear as the IR itself
      if (ir_pc_vld_set) begin
        ir_pc_vld_r <= 1'b1;
      end else if (ir_valid_clr) begin
        ir_pc_vld_r <= 1'b0;
      end
    end
  end

  // New PC loaded but not yet copied, set wins over clear
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      pc_newpend_r <= 1'b0;
    end else if (pc_load) begin
      pc_newpend_r <= 1'b1;
    end else if (ir_pc_vld_set) begin
      pc_newpend_r <= 1'b0;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Datapath registers
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (ir_valid_set) begin
      ir_r[15:0] <= rsp.instr[15:0];
      ir_err_r   <= rsp.err;
    end
    // Upper half is left alone for compressed instructions
    if (ir_valid_set && (ilen == ILEN_32)) begin
      ir_r[31:16] <= rsp.instr[31:16];
    end
    if (ir_pc_vld_set) begin
      ir_pc_r <= pc_r;
    end
  end

  assign o_valid  = ir_valid_r;
  assign o_pc_vld = ir_pc_vld_r;
  assign o.ir     = ir_r;
  assign o.pc     = ir_pc_r;
  assign o.buserr = ir_err_r;

endmodule

`default_nettype wire

// File: logic/ifu_ifetch.sv
// Instruction fetch top: PC generator, request controller and IR stage
// Memory request/response channels and the execute-stage channel
`default_nettype none

module ifu_ifetch (
  input  logic                clk,
  input  logic                arst_n,
  input  ifu_pkg::pc_t        pc_rtvec,
  // Fetch request channel
  output logic                req_valid,
  input  logic                req_ready,
  output ifu_pkg::fetch_req_t req,
  // Fetch response channel
  input  logic                rsp_valid,
  output logic                rsp_ready,
  input  ifu_pkg::fetch_rsp_t rsp,
  // Execute stage channel
  output logic                o_valid,
  output logic                o_pc_vld,
  input  logic                o_ready,
  output ifu_pkg::ir_out_t    o,
  // Pipeline flush, always accepted
  input  logic                flush_req,
  input  ifu_pkg::flush_t     flush,
  // Halt handshake
  input  logic                halt_req,
  output logic                halt_ack
);
  import ifu_pkg::*;

  logic  req_fire;
  logic  rsp_fire;
  logic  pc_load;
  logic  ir_ready;
  ctl_t  ctl;
  pc_t   pc_r;
  pc_t   pc_nxt;
  ilen_e ilen;

  ////////////////////////////////////////////////////////////////////////////
  // Blocks
  ////////////////////////////////////////////////////////////////////////////

  ifu_pc_gen u_pc_gen (
    .clk       (clk),
    .arst_n    (arst_n),
    .pc_rtvec  (pc_rtvec),
    .flush_req (flush_req),
    .flush     (flush),
    .req_fire  (req_fire),
    .ilen      (ilen),
    .ctl       (ctl),
    .pc_r      (pc_r),
    .pc_nxt    (pc_nxt),
    .pc_load   (pc_load)
  );

  ifu_req_ctrl u_req_ctrl (
    .clk       (clk),
    .arst_n    (arst_n),
    .ctl       (ctl),
    .halt_req  (halt_req),
    .req_ready (req_ready),
    .rsp_valid (rsp_valid),
    .ir_ready  (ir_ready),
    .req_valid (req_valid),
    .rsp_ready (rsp_ready),
    .req_fire  (req_fire),
    .rsp_fire  (rsp_fire),
    .halt_ack  (halt_ack)
  );

  ifu_ir_stage u_ir_stage (
    .clk       (clk),
    .arst_n    (arst_n),
    .rsp       (rsp),
    .rsp_fire  (rsp_fire),
    .ctl       (ctl),
    .flush_req (flush_req),
    .pc_load   (pc_load),
    .pc_r      (pc_r),
    .o_ready   (o_ready),
    .ilen      (ilen),
    .ir_ready  (ir_ready),
    .o_valid   (o_valid),
    .o_pc_vld  (o_pc_vld),
    .o         (o)
  );

  // Request payload; sequential unless flush or reset redirect the PC
  assign req.pc      = pc_nxt;
  assign req.seq     = !ctl.flush_real && !ctl.reset_req;
  assign req.last_pc = pc_r;

endmodule

`default_nettype wire

// File: sim/tb_ifu_tasks.svh
// Typed compare tasks, IR output scoreboard and directed test tasks
`ifndef TB_IFU_TASKS_SVH
`define TB_IFU_TASKS_SVH

////////////////////////////////////////////////////////////////////////////
// Compare tasks
////////////////////////////////////////////////////////////////////////////

task automatic stop_failed();
  $display("TEST FAILED");
  $fatal(1, "Simulation stopped on the first failure");
endtask

task automatic check_pc(input string name, input pc_t exp, input pc_t act);
  if (exp !== act) begin
    $display("ERR %s: expected %h, actual %h", name, exp, act);
    stop_failed();
  end
endtask

task automatic check_instr(input string name, input instr_t exp, input instr_t act);
  if (exp !== act) begin
    $display("ERR %s: expected %h, actual %h", name, exp, act);
    stop_failed();
  end
endtask

task automatic check_bit(input string name, input logic exp, input logic act);
  if (exp !== act) begin
    $display("ERR %s: expected %b, actual %b", name, exp, act);
    stop_failed();
  end
endtask

// Flushed requests are dropped, then the oldest live one must match
task automatic score_output();
  pc_t    a;
  instr_t mask;
  while (exp_ep_q.size() > 0 && exp_ep_q[0] != epoch) begin
    void'(exp_pc_q.pop_front());
    void'(exp_ep_q.pop_front());
  end
  if (exp_pc_q.size() == 0) begin
    $display("IR output in %s with no fetch request pending", test_name);
    stop_failed();
  end else begin
    a = exp_pc_q.pop_front();
    void'(exp_ep_q.pop_front());
    // Upper half only counts for 32-bit words
    mask = a[2] ? 32'hffff_ffff : 32'h0000_ffff;
    check_pc(test_name, a, o.pc);
    check_instr(test_name, mem_word(a) & mask, o.ir & mask);
    check_bit(test_name, mem_err(a), o.buserr);
    check_bit(test_name, 1'b1, o_pc_vld);
    out_count = out_count + 1;
    last_out_pc = o.pc;
    if (mem_err(a)) begin
      err_seen = err_seen + 1;
    end
  end
endtask

////////////////////////////////////////////////////////////////////////////
// Wait helpers, sampled on the falling edge
////////////////////////////////////////////////////////////////////////////

task automatic wait_outputs(input int n);
  int target;
  target = out_count + n;
  while (out_count < target) @(negedge clk);
endtask

task automatic wait_requests(input int n);
  int target;
  target = req_count + n;
  while (req_count < target) @(negedge clk);
endtask

// Request outstanding, answer either still two cycles away or due next edge
function automatic logic flush_window(input logic at_rsp);
  if (at_rsp) begin
    return mem_busy && (mem_wait == 2'd1);
  end
  return mem_busy && (mem_wait >= 2'd2);
endfunction

////////////////////////////////////////////////////////////////////////////
// Directed tests
////////////////////////////////////////////////////////////////////////////

task automatic reset_fetch();
  test_name = "reset_fetch";
  wait_requests(1);
  check_pc(test_name, {pc_rtvec[31:1], 1'b0}, first_req.pc);
  check_bit(test_name, 1'b0, first_req.seq);
endtask

// Per-request steps and per-output order are checked by the scoreboard
task automatic seq_stream();
  test_name = "seq_stream";
  wait_outputs(SEQ_N);
endtask

task automatic bus_error();
  int e0;
  test_name = "bus_error";
  e0 = err_seen;
  while (err_seen == e0) @(negedge clk);
  wait_outputs(4);
endtask

task automatic flush_case(input logic at_rsp);
  pc_t op1;
  pc_t op2;
  pc_t target;
  @(negedge clk);
  while (!flush_window(at_rsp)) @(negedge clk);
  test_lfsr = lfsr_adv(test_lfsr, 32);
  op1 = test_lfsr;
  test_lfsr = lfsr_adv(test_lfsr, 32);
  op2 = test_lfsr;
  target = op1 + op2;
  target[0] = 1'b0;
  @(posedge clk);
  flush_req     <= 1'b1;
  flush.add_op1 <= op1;
  flush.add_op2 <= op2;
  @(posedge clk);
  flush_req <= 1'b0;
  @(negedge clk);
  // First output after the flush edge comes from the target
  wait_outputs(1);
  check_pc(test_name, target, last_out_pc);
  wait_outputs(FLUSH_N);
endtask

task automatic flush_test();
  test_name = "flush";
  flush_case(1'b0);
  flush_case(1'b1);
endtask

task automatic halt_test();
  int n0;
  test_name = "halt";
  @(posedge clk);
  halt_req <= 1'b1;
  @(negedge clk);
  n0 = req_count;
  while (!halt_ack) @(negedge clk);
  for (int i = 0; i < HALT_HOLD; i++) begin
    @(negedge clk);
    if (req_count != n0) begin
      $display("A fetch request was accepted while the halt was held");
      stop_failed();
    end
    check_bit(test_name, 1'b1, halt_ack);
  end
  @(posedge clk);
  halt_req <= 1'b0;
  @(negedge clk);
  check_bit(test_name, 1'b1, halt_ack);
  @(negedge clk);
  check_bit(test_name, 1'b0, halt_ack);
  // Resume address is checked as a sequential step
  wait_requests(1);
  wait_outputs(4);
endtask

`endif

// File: sim/tb_ifu.sv
// Testbench top for the instruction fetch unit
// Clock, reset, memory model with scoreboard, EXU sink, LFSR and timeout
`default_nettype none

module tb_ifu;
  import ifu_pkg::*;

  // Outputs per test and cycle budget per IR output
  localparam int SEQ_N       = 24;
  localparam int ERR_N       = 40;
  localparam int FLUSH_N     = 6;
  localparam int HALT_HOLD   = 8;
  localparam int CYC_PER_OUT = 8;
  localparam int TEST_CYCLES = 16 + SEQ_N * CYC_PER_OUT + ERR_N * CYC_PER_OUT
                             + 2 * (FLUSH_N + 8) * CYC_PER_OUT
                             + HALT_HOLD + 8 * CYC_PER_OUT;
  localparam int TIMEOUT     = 4 * TEST_CYCLES;
  localparam logic [31:0] LFSR_SEED = 32'h045947ab;
  // Odd on purpose, bit 0 must be cleared by the DUT
  localparam pc_t RTVEC_PC = 32'h0000_10a9;

  // DUT inputs
  logic       clk       = 1'b0;
  logic       arst_n    = 1'b0;
  pc_t        pc_rtvec  = RTVEC_PC;
  logic       req_ready = 1'b1;
  logic       rsp_valid = 1'b0;
  fetch_rsp_t rsp       = '0;
  logic       o_ready   = 1'b0;
  logic       flush_req = 1'b0;
  flush_t     flush     = '0;
  logic       halt_req  = 1'b0;

  // DUT outputs
  logic       req_valid;
  fetch_req_t req;
  logic       rsp_ready;
  logic       o_valid;
  logic       o_pc_vld;
  ir_out_t    o;
  logic       halt_ack;

  // Memory model state
  logic        mem_busy  = 1'b0;
  logic [1:0]  mem_wait  = 2'd0;
  pc_t         mem_addr  = '0;
  logic [31:0] mem_lfsr  = LFSR_SEED;
  logic [31:0] sink_lfsr = LFSR_SEED;
  logic [31:0] test_lfsr = LFSR_SEED;

  // Scoreboard state
  pc_t         exp_pc      = {RTVEC_PC[31:1], 1'b0};
  logic        exp_seq     = 1'b0;
  // PC register of the DUT, reported as last_pc with each request
  pc_t         exp_last_pc = RESET_PC;
  int          epoch     = 0;
  pc_t         exp_pc_q[$];
  int          exp_ep_q[$];
  int          req_count = 0;
  int          out_count = 0;
  int          err_seen  = 0;
  int          cycles    = 0;
  fetch_req_t  first_req = '0;
  pc_t         last_out_pc = '0;
  string       test_name = "reset";

  always #50 clk = ~clk;

  ifu_ifetch dut0 (
    .clk       (clk),
    .arst_n    (arst_n),
    .pc_rtvec  (pc_rtvec),
    .req_valid (req_valid),
    .req_ready (req_ready),
    .req       (req),
    .rsp_valid (rsp_valid),
    .rsp_ready (rsp_ready),
    .rsp       (rsp),
    .o_valid   (o_valid),
    .o_pc_vld  (o_pc_vld),
    .o_ready   (o_ready),
    .o         (o),
    .flush_req (flush_req),
    .flush     (flush),
    .halt_req  (halt_req),
    .halt_ack  (halt_ack)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////////////////////////////////////////

  // Fibonacci LFSR, taps 32 22 2 1, one step per bit taken
  function automatic logic [31:0] lfsr_adv(input logic [31:0] s, input int n);
    logic [31:0] v;
    v = s;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], v[31] ^ v[21] ^ v[1] ^ v[0]};
    end
    return v;
  endfunction

  // Word at an address, bit 1 follows address bit 2 so that one is 32-bit
  function automatic instr_t mem_word(input pc_t a);
    return {a[31:8] ^ 24'h5a3c1e, a[7:2], a[2], 1'b1};
  endfunction

  function automatic logic mem_err(input pc_t a);
    return (a[7:4] == 4'hf);
  endfunction

  function automatic pc_t fetch_step(input pc_t a);
    return a + (a[2] ? PC_INCR_32 : PC_INCR_16);
  endfunction

  `include "tb_ifu_tasks.svh"

  ////////////////////////////////////////////////////////////////////////////
  // Memory model and scoreboard
  ////////////////////////////////////////////////////////////////////////////

  // Order per edge: last_pc, execute transfer, flush, then request and response
  always @(posedge clk) begin
    if (arst_n) begin
      // PC register still holds its value from before this edge
      if (req_valid && req_ready) begin
        check_pc(test_name, exp_last_pc, req.last_pc);
      end
      if (o_valid && o_ready) begin
        score_output();
      end
      if (flush_req) begin
        epoch   = epoch + 1;
        exp_pc  = flush.add_op1 + flush.add_op2;
        exp_pc[0] = 1'b0;
        exp_seq = 1'b0;
        // PC register takes the flush target on this edge
        exp_last_pc = exp_pc;
      end
      if (rsp_valid && rsp_ready) begin
        rsp_valid <= 1'b0;
      end
      if (req_valid && req_ready) begin
        check_pc(test_name, exp_pc, req.pc);
        check_bit(test_name, exp_seq, req.seq);
        if (req_count == 0) begin
          first_req = req;
        end
        req_count = req_count + 1;
        exp_pc_q.push_back(req.pc);
        exp_ep_q.push_back(epoch);
        exp_pc   = fetch_step(req.pc);
        exp_seq  = 1'b1;
        exp_last_pc = req.pc;
        mem_addr <= req.pc;
        // 0 to 3 idle cycles before the answer
        mem_lfsr = lfsr_adv(mem_lfsr, 2);
        if (mem_lfsr[1:0] == 2'd0) begin
          rsp_valid <= 1'b1;
          rsp.instr <= mem_word(req.pc);
          rsp.err   <= mem_err(req.pc);
        end else begin
          mem_busy <= 1'b1;
          mem_wait <= mem_lfsr[1:0];
        end
      end else if (mem_busy) begin
        if (mem_wait == 2'd1) begin
          rsp_valid <= 1'b1;
          rsp.instr <= mem_word(mem_addr);
          rsp.err   <= mem_err(mem_addr);
          mem_busy  <= 1'b0;
        end
        mem_wait <= mem_wait - 2'd1;
      end
    end
  end

  // EXU sink with random back-pressure
  always @(posedge clk) begin
    sink_lfsr = lfsr_adv(sink_lfsr, 1);
    o_ready <= sink_lfsr[0];
  end

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles >= TIMEOUT) begin
      $display("Timeout in %s, the fetch unit stopped making progress", test_name);
      stop_failed();
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    repeat (4) @(posedge clk);
    arst_n <= 1'b1;
    reset_fetch();
    seq_stream();
    bus_error();
    flush_test();
    halt_test();
    $display("TEST OK");
    $finish;
  end

endmodule

`default_nettype wire

// File: tb.f
+incdir+sim
logic/ifu_pkg.sv
logic/ifu_pc_gen.sv
logic/ifu_req_ctrl.sv
logic/ifu_ir_stage.sv
logic/ifu_ifetch.sv
sim/tb_ifu.sv

// File: Makefile
# Verilator build and run of the instruction fetch testbench

VERILATOR ?= verilator
TOP       ?= tb_ifu
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing

SRCS := $(wildcard logic/*.sv) $(wildcard sim/*.sv) $(wildcard sim/*.svh)
SIM  := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: $(SIM)
	./$(SIM)

clean:
	rm -rf $(BUILD_DIR)
